// File: build.f
+incdir+source
source/cop0_pkg.sv
source/cpu_cop0.sv
source/cop0_breakpoint_match.sv
source/cop0_exception_ctrl.sv
source/cop0_subsystem.sv
verification/cop0_checker.sv
verification/cop0_subsystem_tb.sv

// File: Makefile
TOP = cop0_subsystem_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: verification/cop0_subsystem_tb.sv
// testbench for the coprocessor 0 subsystem
// clock, reset, stimulus table with its driver loop, timeout,
// DUT instance and checker instance

`default_nettype none

`include "cop0_cfg.svh"

module cop0_subsystem_tb;

	typedef enum {k_idle, k_write, k_fetch, k_exc, k_rfe, k_dret} row_kind_t;

	typedef struct packed {
		logic                wr_en;
		cop0_pkg::reg_addr_t addr;
		cop0_pkg::word_t     wr_data;
		logic                pc_valid;
		cop0_pkg::word_t     pc;
		logic                exc_req;
		cop0_pkg::exc_code_t exc_code;
		cop0_pkg::word_t     exc_pc;
		logic                exc_bd;
		logic                rfe;
		logic                dret;
		logic                interlock;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic interlock;
	logic wr_en;
	cop0_pkg::reg_addr_t addr;
	logic [2:0] sel;
	cop0_pkg::word_t wr_data;
	cop0_pkg::word_t rd_data;
	logic pc_valid;
	cop0_pkg::word_t pc;
	logic exc_req;
	cop0_pkg::exc_code_t exc_code;
	cop0_pkg::word_t exc_pc;
	logic exc_bd;
	logic rfe;
	logic dret;
	cop0_pkg::word_t status;
	cop0_pkg::word_t cause;
	cop0_pkg::word_t epc;
	cop0_pkg::word_t debug;
	cop0_pkg::word_t depc;
	logic exception;
	logic dbg_break;
	int check_count;
	int error_count;

	row_t table_q [$];
	cop0_pkg::word_t seed = 32'd27;
	int cycle_count = 0;
	int cycle_limit = 20;

	always #5 clk = ~clk;

	function automatic cop0_pkg::word_t xorshift(input cop0_pkg::word_t x);
		cop0_pkg::word_t v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// for k_exc, a carries the exception code and d[0] the delay slot flag
	task automatic add_row(input row_kind_t kind, input cop0_pkg::reg_addr_t a,
			input cop0_pkg::word_t d, input logic lock);
		row_t r;
		seed = xorshift(seed);
		r = '0;
		r.addr = a;
		r.pc_valid = 1'b1;
		// filler fetches stay in the upper half, away from every breakpoint
		r.pc = seed | 32'h8000_0000;
		r.interlock = lock;
		case (kind)
			k_write: begin
				r.wr_en = 1'b1;
				r.wr_data = d;
			end
			k_fetch: r.pc = d;
			k_exc: begin
				r.exc_req = 1'b1;
				r.exc_code = a;
				r.exc_pc = d;
				r.exc_bd = d[0];
			end
			k_rfe: r.rfe = 1'b1;
			k_dret: r.dret = 1'b1;
			default: ;
		endcase
		table_q.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		wr_en     <= r.wr_en;
		addr      <= r.addr;
		wr_data   <= r.wr_data;
		pc_valid  <= r.pc_valid;
		pc        <= r.pc;
		exc_req   <= r.exc_req;
		exc_code  <= r.exc_code;
		exc_pc    <= r.exc_pc;
		exc_bd    <= r.exc_bd;
		rfe       <= r.rfe;
		dret      <= r.dret;
		interlock <= r.interlock;
	endtask

	task automatic report_counts;
		$display("checks: %0d, errors: %0d", check_count, error_count);
	endtask

	// ------------------------------------------------------------------------
	// stimulus table and driver loop
	// ------------------------------------------------------------------------
	initial begin
		reset     = 1'b1;
		interlock = 1'b0;
		wr_en     = 1'b0;
		addr      = '0;
		sel       = '0;
		wr_data   = '0;
		pc_valid  = 1'b0;
		pc        = '0;
		exc_req   = 1'b0;
		exc_code  = '0;
		exc_pc    = '0;
		exc_bd    = 1'b0;
		rfe       = 1'b0;
		dret      = 1'b0;

		// zeros after reset, unmapped numbers included
		for (int a = 0; a < 32; a++) begin
			add_row(k_idle, 5'(a), '0, 1'b0);
		end
		// all ones into every number, read back through the field masks
		for (int a = 0; a < 32; a++) begin
			add_row(k_write, 5'(a), 32'hffff_ffff, 1'b0);
			add_row(k_idle, 5'(a), '0, 1'b0);
		end
		// four breakpoints, all enabled, interrupts on
		add_row(k_write, `COP0_ADDR_DEBP0, 32'h0000_1003, 1'b0);
		add_row(k_write, `COP0_ADDR_DEBP0 + 5'd1, 32'h0000_2001, 1'b0);
		add_row(k_write, `COP0_ADDR_DEBP0 + 5'd2, 32'h0000_3002, 1'b0);
		add_row(k_write, `COP0_ADDR_DEBP0 + 5'd3, 32'h0000_4000, 1'b0);
		add_row(k_write, `COP0_ADDR_DEBUG, 32'h0000_000f, 1'b0);
		add_row(k_write, `COP0_ADDR_STATUS, 32'h0000_0001, 1'b0);
		// two exceptions deep, then back out with rfe
		add_row(k_exc, 5'd4, 32'h0000_0203, 1'b0);
		add_row(k_exc, 5'd8, 32'h0000_0306, 1'b0);
		add_row(k_rfe, `COP0_ADDR_CAUSE, '0, 1'b0);
		add_row(k_rfe, `COP0_ADDR_EPC, '0, 1'b0);
		// break on bp0, then hit and request ignored until dret
		add_row(k_fetch, `COP0_ADDR_DEPC, 32'h0000_1000, 1'b0);
		add_row(k_idle, `COP0_ADDR_DEPC, '0, 1'b0);
		add_row(k_fetch, `COP0_ADDR_DEBUG, 32'h0000_2000, 1'b0);
		add_row(k_exc, 5'd5, 32'h0000_0500, 1'b0);
		add_row(k_dret, `COP0_ADDR_DEBUG, '0, 1'b0);
		add_row(k_fetch, `COP0_ADDR_DEPC, 32'h0000_3002, 1'b0);
		add_row(k_idle, `COP0_ADDR_DEPC, '0, 1'b0);
		add_row(k_dret, `COP0_ADDR_DEPC, '0, 1'b0);
		// bp3 disabled, and the word after bp0, give no break
		add_row(k_write, `COP0_ADDR_DEBUG, 32'h0000_0007, 1'b0);
		add_row(k_fetch, `COP0_ADDR_DEBUG, 32'h0000_4000, 1'b0);
		add_row(k_fetch, `COP0_ADDR_DEBUG, 32'h0000_1004, 1'b0);
		// hit and request in one cycle
		add_row(k_fetch, `COP0_ADDR_STATUS, 32'h0000_1000, 1'b0);
		add_row(k_exc, 5'd6, 32'h0000_0600, 1'b0);
		add_row(k_dret, `COP0_ADDR_STATUS, '0, 1'b0);
		// frozen cycles: write, request and a pending hit all held
		add_row(k_write, `COP0_ADDR_STATUS, 32'h0000_0000, 1'b1);
		add_row(k_exc, 5'd7, 32'h0000_0701, 1'b1);
		add_row(k_fetch, `COP0_ADDR_DEPC, 32'h0000_2000, 1'b0);
		add_row(k_idle, `COP0_ADDR_DEPC, '0, 1'b1);
		add_row(k_idle, `COP0_ADDR_DEPC, '0, 1'b0);
		add_row(k_dret, `COP0_ADDR_DEBUG, '0, 1'b0);
		repeat (4) add_row(k_idle, `COP0_ADDR_DEBUG, '0, 1'b0);
		cycle_limit = table_q.size() + 20;

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		foreach (table_q[i]) begin
			@(posedge clk);
			apply_row(table_q[i]);
		end
		repeat (2) @(posedge clk);
		report_counts();
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// run limit, counted from the end of reset
	always @(posedge clk) begin
		if (!reset) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("timeout: stimulus table not done after %0d cycles", cycle_count);
				report_counts();
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	cop0_subsystem i_cop0_subsystem (
		.clk       (clk),
		.reset     (reset),
		.interlock (interlock),
		.wr_en     (wr_en),
		.addr      (addr),
		.sel       (sel),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.pc_valid  (pc_valid),
		.pc        (pc),
		.exc_req   (exc_req),
		.exc_code  (exc_code),
		.exc_pc    (exc_pc),
		.exc_bd    (exc_bd),
		.rfe       (rfe),
		.dret      (dret),
		.status    (status),
		.cause     (cause),
		.epc       (epc),
		.debug     (debug),
		.depc      (depc),
		.exception (exception),
		.dbg_break (dbg_break)
	);

	cop0_checker i_cop0_checker (
		.clk         (clk),
		.reset       (reset),
		.interlock   (interlock),
		.wr_en       (wr_en),
		.addr        (addr),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.pc_valid    (pc_valid),
		.pc          (pc),
		.exc_req     (exc_req),
		.exc_code    (exc_code),
		.exc_pc      (exc_pc),
		.exc_bd      (exc_bd),
		.rfe         (rfe),
		.dret        (dret),
		.status      (status),
		.cause       (cause),
		.epc         (epc),
		.debug       (debug),
		.depc        (depc),
		.exception   (exception),
		.dbg_break   (dbg_break),
		.check_count (check_count),
		.error_count (error_count)
	);

endmodule

`default_nettype wire

// File: verification/cop0_checker.sv
// reference model of the coprocessor 0 registers and sequencer
// compares the DUT outputs on every falling clock edge

`default_nettype none

`include "cop0_cfg.svh"

module cop0_checker (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                interlock,
	input  wire logic                wr_en,
	input  wire cop0_pkg::reg_addr_t addr,
	input  wire cop0_pkg::word_t     wr_data,
	input  wire cop0_pkg::word_t     rd_data,
	input  wire logic                pc_valid,
	input  wire cop0_pkg::word_t     pc,
	input  wire logic                exc_req,
	input  wire cop0_pkg::exc_code_t exc_code,
	input  wire cop0_pkg::word_t     exc_pc,
	input  wire logic                exc_bd,
	input  wire logic                rfe,
	input  wire logic                dret,
	input  wire cop0_pkg::word_t     status,
	input  wire cop0_pkg::word_t     cause,
	input  wire cop0_pkg::word_t     epc,
	input  wire cop0_pkg::word_t     debug,
	input  wire cop0_pkg::word_t     depc,
	input  wire logic                exception,
	input  wire logic                dbg_break,
	output int                       check_count,
	output int                       error_count
);

	cop0_pkg::word_t m_status;
	cop0_pkg::word_t m_cause;
	cop0_pkg::word_t m_epc;
	cop0_pkg::word_t m_debug;
	cop0_pkg::word_t m_depc;
	cop0_pkg::word_t m_fetch_pc;
	cop0_pkg::word_t m_bp [`COP0_NUM_BP];
	logic [`COP0_NUM_BP-1:0] m_hit;
	logic m_in_debug;
	int checks = 0;
	int errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	task automatic check_word(input string name, input cop0_pkg::word_t got,
			input cop0_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic cop0_pkg::word_t read_model(input cop0_pkg::reg_addr_t a);
		cop0_pkg::word_t v;
		case (a)
			`COP0_ADDR_STATUS: v = m_status;
			`COP0_ADDR_CAUSE:  v = m_cause;
			`COP0_ADDR_EPC:    v = m_epc;
			`COP0_ADDR_DEBUG:  v = m_debug;
			`COP0_ADDR_DEPC:   v = m_depc;
			default:           v = '0;
		endcase
		for (int n = 0; n < `COP0_NUM_BP; n++) begin
			if (a == cop0_pkg::reg_addr_t'(`COP0_ADDR_DEBP0 + n)) begin
				v = m_bp[n];
			end
		end
		return v;
	endfunction

	// ------------------------------------------------------------------------
	// compare, then advance the model to the next rising edge
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		logic [`COP0_NUM_BP-1:0] next_hit;
		logic exp_brk;
		logic exp_exc;
		if (reset) begin
			m_status   = '0;
			m_cause    = '0;
			m_epc      = '0;
			m_debug    = '0;
			m_depc     = '0;
			m_fetch_pc = '0;
			m_hit      = '0;
			m_in_debug = 1'b0;
			for (int n = 0; n < `COP0_NUM_BP; n++) begin
				m_bp[n] = '0;
			end
		end
		// a pending hit outranks a request, debug mode masks both
		exp_brk = !m_in_debug && (|m_hit);
		exp_exc = !m_in_debug && exc_req && !(|m_hit);
		check_word("dbg_break", 32'(dbg_break), 32'(exp_brk));
		check_word("exception", 32'(exception), 32'(exp_exc));
		check_word("rd_data", rd_data, read_model(addr));
		check_word("status", status, m_status);
		check_word("cause", cause, m_cause);
		check_word("epc", epc, m_epc);
		check_word("debug", debug, m_debug);
		check_word("depc", depc, m_depc);

		if (!reset && !interlock) begin
			for (int n = 0; n < `COP0_NUM_BP; n++) begin
				next_hit[n] = pc_valid && m_debug[n] && (pc[31:2] == m_bp[n][31:2]);
			end
			if (exp_exc) begin
				m_status[4] = m_status[2];
				m_status[2] = m_status[0];
				m_status[0] = 1'b0;
				m_cause[`COP0_CAUSE_BD] = exc_bd;
				m_cause[6:2] = exc_code;
				m_epc = exc_pc & 32'hffff_fffc;
			end else begin
				if (rfe) begin
					m_status[0] = m_status[2];
					m_status[2] = m_status[4];
				end else if (wr_en && addr == `COP0_ADDR_STATUS) begin
					m_status = wr_data & 32'h0000_0015;
				end
				if (wr_en && addr == `COP0_ADDR_CAUSE) begin
					m_cause = wr_data & 32'h8000_007c;
				end
				if (wr_en && addr == `COP0_ADDR_EPC) begin
					m_epc = wr_data & 32'hffff_fffc;
				end
			end
			if (exp_brk) begin
				m_debug[`COP0_DEBUG_DM] = 1'b1;
				m_depc = m_fetch_pc & 32'hffff_fffc;
			end else begin
				if (dret) begin
					m_debug[`COP0_DEBUG_DM] = 1'b0;
				end else if (wr_en && addr == `COP0_ADDR_DEBUG) begin
					m_debug[`COP0_DEBUG_DM] = wr_data[`COP0_DEBUG_DM];
					m_debug[`COP0_NUM_BP-1:0] = wr_data[`COP0_NUM_BP-1:0];
				end
				if (wr_en && addr == `COP0_ADDR_DEPC) begin
					m_depc = wr_data & 32'hffff_fffc;
				end
			end
			for (int n = 0; n < `COP0_NUM_BP; n++) begin
				if (wr_en && addr == cop0_pkg::reg_addr_t'(`COP0_ADDR_DEBP0 + n)) begin
					m_bp[n] = wr_data & 32'hffff_fffc;
				end
			end
			// sequencer state
			if (exp_brk) begin
				m_in_debug = 1'b1;
			end else if (m_in_debug && dret) begin
				m_in_debug = 1'b0;
			end
			if (pc_valid) begin
				m_fetch_pc = pc;
			end
			m_hit = next_hit;
		end
	end

endmodule

`default_nettype wire

// File: source/cop0_subsystem.sv
// coprocessor 0 subsystem top level
// register file, breakpoint comparators and exception sequencer

`default_nettype none

`include "cop0_cfg.svh"

module cop0_subsystem (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                interlock,
	// register port
	input  wire logic                wr_en,
	input  wire cop0_pkg::reg_addr_t addr,
	input  wire logic [2:0]          sel,
	input  wire cop0_pkg::word_t     wr_data,
	output cop0_pkg::word_t          rd_data,
	// fetch monitor
	input  wire logic                pc_valid,
	input  wire cop0_pkg::word_t     pc,
	// exception request
	input  wire logic                exc_req,
	input  wire cop0_pkg::exc_code_t exc_code,
	input  wire cop0_pkg::word_t     exc_pc,
	input  wire logic                exc_bd,
	// returns
	input  wire logic                rfe,
	input  wire logic                dret,
	// observation
	output cop0_pkg::word_t          status,
	output cop0_pkg::word_t          cause,
	output cop0_pkg::word_t          epc,
	output cop0_pkg::word_t          debug,
	output cop0_pkg::word_t          depc,
	output logic                     exception,
	output logic                     dbg_break
);

	cop0_pkg::word_t          bp_addr [0:`COP0_NUM_BP-1];
	logic [`COP0_NUM_BP-1:0]  bp_enable;
	logic [`COP0_NUM_BP-1:0]  hit;
	cop0_pkg::word_t          cause_in;
	cop0_pkg::word_t          epc_in;
	cop0_pkg::word_t          depc_in;

	cpu_cop0 i_cpu_cop0 (
		.clk       (clk),
		.reset     (reset),
		.interlock (interlock),
		.wr_en     (wr_en),
		.addr      (addr),
		.sel       (sel),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.exception (exception),
		.rfe       (rfe),
		.dret      (dret),
		.dbg_break (dbg_break),
		.cause_in  (cause_in),
		.epc_in    (epc_in),
		.depc_in   (depc_in),
		.status    (status),
		.cause     (cause),
		.epc       (epc),
		.debug     (debug),
		.depc      (depc),
		.bp_addr   (bp_addr),
		.bp_enable (bp_enable)
	);

	// ------------------------------------------------------------------------
	// one comparator per breakpoint register
	// ------------------------------------------------------------------------
	for (genvar n = 0; n < `COP0_NUM_BP; n++) begin : g_bp
		cop0_breakpoint_match i_match (
			.clk       (clk),
			.reset     (reset),
			.interlock (interlock),
			.pc_valid  (pc_valid),
			.pc        (pc),
			.bp_addr   (bp_addr[n]),
			.enable    (bp_enable[n]),
			.hit       (hit[n])
		);
	end

	cop0_exception_ctrl i_exception_ctrl (
		.clk       (clk),
		.reset     (reset),
		.interlock (interlock),
		.hit       (hit),
		.pc_valid  (pc_valid),
		.pc        (pc),
		.exc_req   (exc_req),
		.exc_code  (exc_code),
		.exc_pc    (exc_pc),
		.exc_bd    (exc_bd),
		.dret      (dret),
		.exception (exception),
		.dbg_break (dbg_break),
		.cause_in  (cause_in),
		.epc_in    (epc_in),
		.depc_in   (depc_in)
	);

endmodule

`default_nettype wire

// File: source/cop0_exception_ctrl.sv
// exception sequencer
// run/debug state machine, debug break before exception,
// fetch pc latch and capture values for the register file

`default_nettype none

`include "cop0_cfg.svh"

module cop0_exception_ctrl (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     interlock,
	input  wire logic [`COP0_NUM_BP-1:0]  hit,
	input  wire logic                     pc_valid,
	input  wire cop0_pkg::word_t          pc,
	input  wire logic                     exc_req,
	input  wire cop0_pkg::exc_code_t      exc_code,
	input  wire cop0_pkg::word_t          exc_pc,
	input  wire logic                     exc_bd,
	input  wire logic                     dret,
	output logic                          exception,
	output logic                          dbg_break,
	output cop0_pkg::word_t               cause_in,
	output cop0_pkg::word_t               epc_in,
	output cop0_pkg::word_t               depc_in
);

	cop0_pkg::ctl_state_t state;
	cop0_pkg::ctl_state_t state_next;
	cop0_pkg::word_t      fetch_pc_q;

	logic hit_any;
	logic in_run;

	assign hit_any = |hit;
	assign in_run  = (state == cop0_pkg::ctl_run);

	// ------------------------------------------------------------------------
	// event strobes
	// ------------------------------------------------------------------------

	// a hit masks a coinciding request, debug state masks both
	assign dbg_break = in_run && hit_any;
	assign exception = in_run && exc_req && !hit_any;

	// ------------------------------------------------------------------------
	// capture values, meaningful only with their strobe
	// ------------------------------------------------------------------------
	always_comb begin
		cause_in                 = '0;
		cause_in[`COP0_CAUSE_BD] = exc_bd;
		cause_in[6:2]            = exc_code;
	end

	assign epc_in  = exc_pc;

	// hit is one cycle behind the fetch, so report the latched pc
	assign depc_in = fetch_pc_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			fetch_pc_q <= '0;
		end else if (pc_valid && !interlock) begin
			fetch_pc_q <= pc;
		end
	end

	// ------------------------------------------------------------------------
	// run/debug state machine
	// ------------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			cop0_pkg::ctl_run: begin
				if (hit_any) begin
					state_next = cop0_pkg::ctl_debug;
				end
			end
			cop0_pkg::ctl_debug: begin
				if (dret) begin
					state_next = cop0_pkg::ctl_run;
				end
			end
			default: state_next = cop0_pkg::ctl_run;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cop0_pkg::ctl_run;
		end else if (!interlock) begin
			state <= state_next;
		end
	end

	// a taken break parks the sequencer in debug, so no second
	// break can follow directly behind it
	a_single_break: assert property (@(posedge clk) disable iff (reset)
		dbg_break && !interlock |=> state == cop0_pkg::ctl_debug && !dbg_break);

endmodule

`default_nettype wire

// File: source/cop0_breakpoint_match.sv
// instruction breakpoint comparator
// word compare of the fetch pc against one breakpoint register,
// result registered for the next cycle

`default_nettype none

module cop0_breakpoint_match (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            interlock,
	input  wire logic            pc_valid,
	input  wire cop0_pkg::word_t pc,
	input  wire cop0_pkg::word_t bp_addr,
	input  wire logic            enable,
	output logic                 hit
);

	logic match;

	// byte offset bits take no part in the compare
	assign match = pc_valid && enable && (pc[31:2] == bp_addr[31:2]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hit <= 1'b0;
		end else if (!interlock) begin
			hit <= match;
		end
	end

endmodule

`default_nettype wire

// File: source/cpu_cop0.sv
// coprocessor 0 register file
// status stack, cause, epc, debug, depc and breakpoint addresses
// with event capture and the combinational read port

`default_nettype none

`include "cop0_cfg.svh"

module cpu_cop0 (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                interlock,
	input  wire logic                wr_en,
	input  wire cop0_pkg::reg_addr_t addr,
	input  wire logic [2:0]          sel,
	input  wire cop0_pkg::word_t     wr_data,
	output cop0_pkg::word_t          rd_data,
	input  wire logic                exception,
	input  wire logic                rfe,
	input  wire logic                dret,
	input  wire logic                dbg_break,
	input  wire cop0_pkg::word_t     cause_in,
	input  wire cop0_pkg::word_t     epc_in,
	input  wire cop0_pkg::word_t     depc_in,
	output cop0_pkg::word_t          status,
	output cop0_pkg::word_t          cause,
	output cop0_pkg::word_t          epc,
	output cop0_pkg::word_t          debug,
	output cop0_pkg::word_t          depc,
	output cop0_pkg::word_t          bp_addr [0:`COP0_NUM_BP-1],
	output logic [`COP0_NUM_BP-1:0]  bp_enable
);

	cop0_pkg::word_t status_q;
	cop0_pkg::word_t cause_q;
	cop0_pkg::word_t epc_q;
	cop0_pkg::word_t debug_q;
	cop0_pkg::word_t depc_q;
	cop0_pkg::word_t bp_q [0:`COP0_NUM_BP-1];

	logic wr_status;
	logic wr_cause;
	logic wr_epc;
	logic wr_debug;
	logic wr_depc;

	// sel only exists for compatibility, no register has a second select
	assign wr_status = wr_en && (addr == `COP0_ADDR_STATUS);
	assign wr_cause  = wr_en && (addr == `COP0_ADDR_CAUSE);
	assign wr_epc    = wr_en && (addr == `COP0_ADDR_EPC);
	assign wr_debug  = wr_en && (addr == `COP0_ADDR_DEBUG);
	assign wr_depc   = wr_en && (addr == `COP0_ADDR_DEPC);

	// ------------------------------------------------------------------------
	// register update, events win over writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			status_q <= '0;
			cause_q  <= '0;
			epc_q    <= '0;
			debug_q  <= '0;
			depc_q   <= '0;
			for (int n = 0; n < `COP0_NUM_BP; n++) begin
				bp_q[n] <= '0;
			end
		end else if (!interlock) begin
			// status: three level interrupt enable stack in bits 0/2/4
			if (exception) begin
				status_q[0] <= 1'b0;
				status_q[2] <= status_q[0];
				status_q[4] <= status_q[2];
			end else if (rfe) begin
				status_q[0] <= status_q[2];
				status_q[2] <= status_q[4];
			end else if (wr_status) begin
				status_q[0] <= wr_data[0];
				status_q[2] <= wr_data[2];
				status_q[4] <= wr_data[4];
			end

			// cause: bd flag and exception code
			if (exception) begin
				cause_q[`COP0_CAUSE_BD] <= cause_in[`COP0_CAUSE_BD];
				cause_q[6:2]            <= cause_in[6:2];
			end else if (wr_cause) begin
				cause_q[`COP0_CAUSE_BD] <= wr_data[`COP0_CAUSE_BD];
				cause_q[6:2]            <= wr_data[6:2];
			end

			// epc, word aligned
			if (exception) begin
				epc_q[31:2] <= epc_in[31:2];
			end else if (wr_epc) begin
				epc_q[31:2] <= wr_data[31:2];
			end

			// debug: mode flag plus breakpoint enables
			if (dbg_break) begin
				debug_q[`COP0_DEBUG_DM] <= 1'b1;
			end else if (dret) begin
				debug_q[`COP0_DEBUG_DM] <= 1'b0;
			end else if (wr_debug) begin
				debug_q[`COP0_DEBUG_DM]  <= wr_data[`COP0_DEBUG_DM];
				debug_q[`COP0_NUM_BP-1:0] <= wr_data[`COP0_NUM_BP-1:0];
			end

			// depc, word aligned
			if (dbg_break) begin
				depc_q[31:2] <= depc_in[31:2];
			end else if (wr_depc) begin
				depc_q[31:2] <= wr_data[31:2];
			end

			// breakpoint addresses, software written only
			for (int n = 0; n < `COP0_NUM_BP; n++) begin
				if (wr_en && (addr == cop0_pkg::reg_addr_t'(`COP0_ADDR_DEBP0 + n))) begin
					bp_q[n][31:2] <= wr_data[31:2];
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// read port, unmapped numbers read zero
	// ------------------------------------------------------------------------
	always_comb begin
		case (addr)
			`COP0_ADDR_STATUS: rd_data = status_q;
			`COP0_ADDR_CAUSE:  rd_data = cause_q;
			`COP0_ADDR_EPC:    rd_data = epc_q;
			`COP0_ADDR_DEBUG:  rd_data = debug_q;
			`COP0_ADDR_DEPC:   rd_data = depc_q;
			default:           rd_data = '0;
		endcase
		for (int n = 0; n < `COP0_NUM_BP; n++) begin
			if (addr == cop0_pkg::reg_addr_t'(`COP0_ADDR_DEBP0 + n)) begin
				rd_data = bp_q[n];
			end
		end
	end

	assign status    = status_q;
	assign cause     = cause_q;
	assign epc       = epc_q;
	assign debug     = debug_q;
	assign depc      = depc_q;
	assign bp_addr   = bp_q;
	assign bp_enable = debug_q[`COP0_NUM_BP-1:0];

	// sequencer never raises both events, and the pipeline never returns
	// from an exception in the cycle one is taken
	a_break_excl: assert property (@(posedge clk) disable iff (reset)
		!(exception && dbg_break));
	a_rfe_excl: assert property (@(posedge clk) disable iff (reset)
		!(exception && rfe));

endmodule

`default_nettype wire

// File: source/cop0_pkg.sv
// coprocessor 0 shared types
// data word, register number, exception code and sequencer state

`default_nettype none

package cop0_pkg;

	// ------------------------------------------------------------------------
	// data path widths
	// ------------------------------------------------------------------------

	// full machine word
	typedef logic [31:0] word_t;

	// coprocessor register number
	typedef logic [4:0] reg_addr_t;

	// exception code, stored in cause[6:2]
	typedef logic [4:0] exc_code_t;

	// ------------------------------------------------------------------------
	// exception sequencer
	// ------------------------------------------------------------------------

	// run: normal execution, breakpoints and exceptions accepted
	// debug: break taken, everything waits for dret
	typedef enum logic {
		ctl_run   = 1'b0,
		ctl_debug = 1'b1
	} ctl_state_t;

endpackage

`default_nettype wire

// File: source/cop0_cfg.svh
// coprocessor 0 configuration macros
// register numbers, breakpoint count and field bit positions

`ifndef COP0_CFG_SVH
`define COP0_CFG_SVH

// ---------------------------------------------------------------------------
// breakpoint comparators, legal range 1 to 4
// ---------------------------------------------------------------------------
`define COP0_NUM_BP 4

// ---------------------------------------------------------------------------
// register numbers
// ---------------------------------------------------------------------------
`define COP0_ADDR_STATUS 5'd12
`define COP0_ADDR_CAUSE 5'd13
`define COP0_ADDR_EPC 5'd14
// breakpoint n sits at debp0 + n
`define COP0_ADDR_DEBP0 5'd16
`define COP0_ADDR_DEBUG 5'd23
`define COP0_ADDR_DEPC 5'd24

// ---------------------------------------------------------------------------
// field positions
// ---------------------------------------------------------------------------
// debug mode flag in debug
`define COP0_DEBUG_DM 31
// branch delay flag in cause
`define COP0_CAUSE_BD 31

`endif
